/* Makefile */
# Verilator simulation of the boot image loader

VERILATOR ?= verilator
TOP       ?= tb_boot_loader
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, pass if the log holds the pass message"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* logic/boot_commit.sv */
////////////////////////////////////////
// Stage 3 of the boot loader: drives the memory
// write and records which upper-ROM pages are loaded
////////////////////////////////////////

`timescale 1ns/1ps
`include "boot_params.svh"

module boot_commit (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic [`BOOT_ADDR_W-1:0] mem_addr_i,
	input  logic [`BANK_W-1:0]      bank_i,
	input  logic [7:0]              data_i,
	input  logic                    wr_i,
	output logic                    boot_wr_o,
	output logic [`BOOT_ADDR_W-1:0] boot_addr_o,
	output logic [`BANK_W-1:0]      boot_bank_o,
	output logic [7:0]              boot_data_o,
	output logic [`MAP_W-1:0]       rom_map_o
);

	logic upper_hit;

	// Write lands in the upper-ROM half
	assign upper_hit = wr_i & mem_addr_i[`BOOT_ADDR_W-1];

	////////////////////////////////////////
	// Strobe and presence map
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			boot_wr_o <= 1'b0;
			rom_map_o <= '0;
		end else begin
			boot_wr_o <= wr_i;
			if (upper_hit)
				rom_map_o[mem_addr_i[`BOOT_ADDR_W-2:`BLK_AW]] <= 1'b1;
		end
	end

	// Write payload
	always_ff @(posedge clk_sys) begin
		boot_addr_o <= mem_addr_i;
		boot_bank_o <= bank_i;
		boot_data_o <= data_i;
	end

endmodule

/* logic/boot_loader.sv */
////////////////////////////////////////
// Boot image loader top: host download stream in,
// memory writes and upper-ROM map out
////////////////////////////////////////

`timescale 1ns/1ps
`include "boot_params.svh"

module boot_loader (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     ioctl_download_i,
	input  logic [`DL_IDX_W-1:0]     ioctl_index_i,
	input  logic                     ioctl_wr_i,
	input  logic [`IOCTL_ADDR_W-1:0] ioctl_addr_i,
	input  logic [7:0]               ioctl_dout_i,
	input  logic [15:0]              ioctl_ext_i,
	input  logic                     model_i,
	output logic                     boot_wr_o,
	output logic [`BOOT_ADDR_W-1:0]  boot_addr_o,
	output logic [`BANK_W-1:0]       boot_bank_o,
	output logic [7:0]               boot_data_o,
	output logic [`MAP_W-1:0]        rom_map_o,
	output logic                     hold_reset_o
);
	import boot_pkg::*;

	// Decode to address map
	dl_kind_e                 s1_kind;
	logic [`PAGE_W-1:0]       s1_page;
	logic [`IOCTL_ADDR_W-1:0] s1_addr;
	logic [7:0]               s1_data;
	logic                     s1_wr;
	logic                     s1_model;

	// Address map to commit
	logic [`BOOT_ADDR_W-1:0]  s2_addr;
	logic [`BANK_W-1:0]       s2_bank;
	logic [7:0]               s2_data;
	logic                     s2_wr;

	dl_decode u_decode (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_index_i    (ioctl_index_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_dout_i     (ioctl_dout_i),
		.ioctl_ext_i      (ioctl_ext_i),
		.model_i          (model_i),
		.kind_o           (s1_kind),
		.page_o           (s1_page),
		.addr_o           (s1_addr),
		.data_o           (s1_data),
		.wr_o             (s1_wr),
		.model_o          (s1_model),
		.hold_reset_o     (hold_reset_o)
	);

	rom_slot_map u_map (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.kind_i     (s1_kind),
		.page_i     (s1_page),
		.addr_i     (s1_addr),
		.data_i     (s1_data),
		.wr_i       (s1_wr),
		.model_i    (s1_model),
		.mem_addr_o (s2_addr),
		.bank_o     (s2_bank),
		.data_o     (s2_data),
		.wr_o       (s2_wr)
	);

	boot_commit u_commit (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.mem_addr_i  (s2_addr),
		.bank_i      (s2_bank),
		.data_i      (s2_data),
		.wr_i        (s2_wr),
		.boot_wr_o   (boot_wr_o),
		.boot_addr_o (boot_addr_o),
		.boot_bank_o (boot_bank_o),
		.boot_data_o (boot_data_o),
		.rom_map_o   (rom_map_o)
	);

endmodule

/* logic/boot_params.svh */
////////////////////////////////////////
// Widths, download indices and ROM slot pages
// for the boot image loader, include where needed
////////////////////////////////////////

`ifndef BOOT_PARAMS_SVH
`define BOOT_PARAMS_SVH

// Widths
`define BOOT_ADDR_W   23    // Memory word address
`define IOCTL_ADDR_W  25    // Host stream address
`define PAGE_W        9     // Bit 8 selects upper-ROM half
`define BLK_AW        14    // Offset bits inside a 16 KB block
`define DL_IDX_W      8
`define BANK_W        2
`define MAP_W         256   // One bit per upper-ROM page

// Host download indices
`define DL_IDX_ROM    8'd0
`define DL_IDX_EXT    8'd3

// System ROM slots
`define PAGE_OS       9'h000
`define PAGE_BASIC    9'h100
`define PAGE_AMSDOS   9'h107
`define PAGE_CART     9'h0FF

// Unused page for a broken extension
`define PAGE_BAD      9'h1EE
`define PAGE_COMBO    9'h1FF  // Base after first block of a combined image

`endif

/* logic/boot_pkg.sv */
////////////////////////////////////////
// Shared types of the boot image loader
////////////////////////////////////////

package boot_pkg;

	// Kind of the running download
	// Produced by the decode stage, consumed by the address map
	typedef enum logic [1:0] {
		DL_NONE = 2'd0,  // No loader download active
		DL_ROM  = 2'd1,  // System ROM set, fixed slots
		DL_EXT  = 2'd2   // Expansion ROM, page from extension
	} dl_kind_e;

endpackage

/* logic/dl_decode.sv */
////////////////////////////////////////
// Stage 1 of the boot loader: classifies the download,
// decodes the expansion page and registers each write
////////////////////////////////////////

`timescale 1ns/1ps
`include "boot_params.svh"

module dl_decode (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     ioctl_download_i,
	input  logic [`DL_IDX_W-1:0]     ioctl_index_i,
	input  logic                     ioctl_wr_i,
	input  logic [`IOCTL_ADDR_W-1:0] ioctl_addr_i,
	input  logic [7:0]               ioctl_dout_i,
	input  logic [15:0]              ioctl_ext_i,
	input  logic                     model_i,
	output boot_pkg::dl_kind_e       kind_o,
	output logic [`PAGE_W-1:0]       page_o,
	output logic [`IOCTL_ADDR_W-1:0] addr_o,
	output logic [7:0]               data_o,
	output logic                     wr_o,
	output logic                     model_o,
	output logic                     hold_reset_o
);
	import boot_pkg::*;

	logic               rom_dl;
	logic               ext_dl;
	logic               dl_start;
	logic               download_q;
	logic               model_q;
	logic               combo_q;
	logic               combo_dec;
	logic               combo_cur;
	logic               combo_end;
	logic [`PAGE_W-1:0] page_q;
	logic [`PAGE_W-1:0] page_dec;
	logic [`PAGE_W-1:0] page_cur;
	logic [4:0]         hi_nib;
	logic [4:0]         lo_nib;
	dl_kind_e           kind_cur;

	// ASCII hex digit to {valid, value}
	function automatic logic [4:0] hex_nibble(input logic [7:0] c);
		logic [4:0] r;
		r = 5'd0;
		if (c >= "0" && c <= "9")
			r = {1'b1, c[3:0]};
		else if (c >= "A" && c <= "F")
			r = {1'b1, c[3:0] + 4'd9};
		return r;
	endfunction

	assign rom_dl   = ioctl_download_i && (ioctl_index_i == `DL_IDX_ROM);
	assign ext_dl   = ioctl_download_i && (ioctl_index_i == `DL_IDX_EXT);
	assign dl_start = ioctl_download_i & ~download_q;
	assign hi_nib   = hex_nibble(ioctl_ext_i[15:8]);
	assign lo_nib   = hex_nibble(ioctl_ext_i[7:0]);

	////////////////////////////////////////
	// Extension decode
	always_comb begin
		page_dec  = `PAGE_BAD;
		combo_dec = 1'b0;
		if (hi_nib[4] && lo_nib[4])
			page_dec = {1'b0, hi_nib[3:0], lo_nib[3:0]};
		if (ioctl_ext_i == "ZZ")
			page_dec = '0;
		if (ioctl_ext_i == "Z0") begin
			page_dec  = '0;
			combo_dec = 1'b1;  // Combined image starts at page 0
		end
	end

	// Decoded value is used by a strobe in the start cycle too
	assign page_cur  = (dl_start && ext_dl) ? page_dec : page_q;
	assign combo_cur = (dl_start && ext_dl) ? combo_dec : combo_q;
	assign combo_end = combo_cur && ext_dl && ioctl_wr_i && (&ioctl_addr_i[`BLK_AW-1:0]);
	assign kind_cur  = rom_dl ? DL_ROM : (ext_dl ? DL_EXT : DL_NONE);
	assign model_o   = model_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_q   <= 1'b0;
			model_q      <= 1'b0;
			combo_q      <= 1'b0;
			page_q       <= `PAGE_BAD;
			kind_o       <= DL_NONE;
			wr_o         <= 1'b0;
			hold_reset_o <= 1'b0;
		end else begin
			download_q   <= ioctl_download_i;
			hold_reset_o <= rom_dl | ext_dl;
			kind_o       <= kind_cur;
			wr_o         <= ioctl_wr_i & (rom_dl | ext_dl);
			if (dl_start)
				model_q <= model_i;
			if (combo_end) begin
				page_q  <= `PAGE_COMBO;  // Last byte of block 0 still uses page 0
				combo_q <= 1'b0;
			end else begin
				page_q  <= page_cur;
				combo_q <= combo_cur;
			end
		end
	end

	// Payload
	always_ff @(posedge clk_sys) begin
		page_o <= page_cur;
		addr_o <= ioctl_addr_i;
		data_o <= ioctl_dout_i;
	end

endmodule

/* logic/rom_slot_map.sv */
////////////////////////////////////////
// Stage 2 of the boot loader: maps a stream
// address to a memory address and bank
////////////////////////////////////////

`timescale 1ns/1ps
`include "boot_params.svh"

module rom_slot_map (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  boot_pkg::dl_kind_e       kind_i,
	input  logic [`PAGE_W-1:0]       page_i,
	input  logic [`IOCTL_ADDR_W-1:0] addr_i,
	input  logic [7:0]               data_i,
	input  logic                     wr_i,
	input  logic                     model_i,
	output logic [`BOOT_ADDR_W-1:0]  mem_addr_o,
	output logic [`BANK_W-1:0]       bank_o,
	output logic [7:0]               data_o,
	output logic                     wr_o
);
	import boot_pkg::*;

	logic [`IOCTL_ADDR_W-`BLK_AW-1:0] blk;
	logic [`BOOT_ADDR_W-1:0]          addr_nx;
	logic [`BANK_W-1:0]               bank_nx;
	logic                             wr_nx;

	assign blk = addr_i[`IOCTL_ADDR_W-1:`BLK_AW];  // 16 KB block number

	// Low half of memory holds OS and RAM, upper half the upper ROMs
	always_comb begin
		addr_nx                             = '1;
		addr_nx[`BLK_AW-1:0]                = addr_i[`BLK_AW-1:0];
		bank_nx                             = '0;
		wr_nx                               = wr_i;
		case (kind_i)
			DL_EXT: begin
				addr_nx[`BOOT_ADDR_W-1]            = page_i[`PAGE_W-1];
				addr_nx[`BOOT_ADDR_W-2:`BLK_AW]    = page_i[7:0] + addr_i[21:14];
				bank_nx                            = {1'b0, model_i};
			end
			DL_ROM: begin
				case (blk)
					11'd0, 11'd4: addr_nx[`BOOT_ADDR_W-1:`BLK_AW] = `PAGE_OS;
					11'd1, 11'd5: addr_nx[`BOOT_ADDR_W-1:`BLK_AW] = `PAGE_BASIC;
					11'd2, 11'd6: addr_nx[`BOOT_ADDR_W-1:`BLK_AW] = `PAGE_AMSDOS;
					11'd3, 11'd7: addr_nx[`BOOT_ADDR_W-1:`BLK_AW] = `PAGE_CART;
					default:      wr_nx = 1'b0;  // Beyond the second model set
				endcase
				bank_nx = {1'b0, blk[2]};  // Blocks 4-7 belong to the second model
			end
			default: wr_nx = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			wr_o <= 1'b0;
		else
			wr_o <= wr_nx;
	end

	always_ff @(posedge clk_sys) begin
		mem_addr_o <= addr_nx;
		bank_o     <= bank_nx;
		data_o     <= data_i;
	end

endmodule

/* sim.f */
+incdir+logic
logic/boot_pkg.sv
logic/dl_decode.sv
logic/rom_slot_map.sv
logic/boot_commit.sv
logic/boot_loader.sv
tests/boot_checker.sv
tests/boot_loader_sva.sv
tests/tb_boot_loader.sv

/* tests/boot_checker.sv */
////////////////////////////////////////
// Testbench checker: queue of expected memory
// writes, compared against every boot_wr_o
////////////////////////////////////////

`timescale 1ns/1ps
`include "boot_params.svh"

module boot_checker (
	input logic                    clk_sys,
	input logic                    reset,
	input logic                    boot_wr_i,
	input logic [`BOOT_ADDR_W-1:0] boot_addr_i,
	input logic [`BANK_W-1:0]      boot_bank_i,
	input logic [7:0]              boot_data_i
);

	typedef struct packed {
		logic [`BOOT_ADDR_W-1:0] addr;
		logic [`BANK_W-1:0]      bank;
		logic [7:0]              data;
		logic [31:0]             due;   // Cycle the write must show up
	} wr_exp_t;

	wr_exp_t exp_q[$];
	int      cyc     = 0;
	int      err_cnt = 0;
	int      wr_cnt  = 0;

	always @(posedge clk_sys)
		cyc <= cyc + 1;

	// Called on a falling edge while the strobe is driven
	task automatic push_write(input logic [`BOOT_ADDR_W-1:0] addr,
			input logic [`BANK_W-1:0] bank, input logic [7:0] data);
		wr_exp_t e;
		e.addr = addr;
		e.bank = bank;
		e.data = data;
		e.due  = cyc + 3;  // One register per stage
		exp_q.push_back(e);
	endtask

	function automatic int pending();
		return exp_q.size();
	endfunction

	task automatic check_value(input string name, input logic [255:0] got,
			input logic [255:0] exp);
		if (got !== exp) begin
			$display("MISMATCH t=%0t %s got %h exp %h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	////////////////////////////////////////
	// Compare on the falling edge, outputs are stable there
	always @(negedge clk_sys) begin : cmp_blk
		wr_exp_t e;
		if (!reset && boot_wr_i) begin
			if (exp_q.size() == 0) begin
				$display("t=%0t: write to %h arrived with no write expected", $time, boot_addr_i);
				err_cnt++;
			end else begin
				e = exp_q.pop_front();
				wr_cnt++;
				check_value("boot_addr_o", boot_addr_i, e.addr);
				check_value("boot_bank_o", boot_bank_i, e.bank);
				check_value("boot_data_o", boot_data_i, e.data);
				check_value("boot_wr_o cycle", cyc, e.due);
			end
		end
	end

	task automatic final_check();
		if (exp_q.size() != 0) begin
			$display("%0d expected writes never arrived", exp_q.size());
			err_cnt++;
		end
	endtask

endmodule

/* tests/boot_loader_sva.sv */
////////////////////////////////////////
// Assertions on write strobe and reset,
// bound to the loader top
////////////////////////////////////////

`timescale 1ns/1ps
`include "boot_params.svh"

module boot_loader_sva (
	input logic              clk_sys,
	input logic              reset,
	input logic              ioctl_wr_i,
	input logic              boot_wr_o,
	input logic [`MAP_W-1:0] rom_map_o
);

	// Each write goes back to a host strobe three cycles earlier
	a_wr_origin: assert property (@(posedge clk_sys) disable iff (reset)
		boot_wr_o |-> $past(ioctl_wr_i, 3))
		else $error("boot_wr_o without a matching host strobe");

	a_wr_reset: assert property (@(posedge clk_sys) $past(reset) |-> !boot_wr_o)
		else $error("boot_wr_o high during reset");

	a_map_clear: assert property (@(posedge clk_sys) $fell(reset) |-> (rom_map_o == '0))
		else $error("rom_map_o not cleared by reset");

endmodule

/* tests/tb_boot_loader.sv */
////////////////////////////////////////
// Testbench of the boot loader: applies a table
// of downloads and predicts every memory write
////////////////////////////////////////

`timescale 1ns/1ps
`include "boot_params.svh"

module tb_boot_loader;

	localparam int N_DL    = 10;
	localparam int MAX_GAP = 3;

	typedef struct {
		logic [7:0]               idx;
		logic [15:0]              ext;
		logic                     model;
		logic [`IOCTL_ADDR_W-1:0] start;
		logic [`IOCTL_ADDR_W-1:0] stride;
		int                       count;
		logic [`PAGE_W-1:0]       page;  // Expected start page, expansion only
	} dl_entry_t;

	logic                     clk_sys = 1'b0;
	logic                     reset;
	logic                     ioctl_download_i;
	logic [7:0]               ioctl_index_i;
	logic                     ioctl_wr_i;
	logic [`IOCTL_ADDR_W-1:0] ioctl_addr_i;
	logic [7:0]               ioctl_dout_i;
	logic [15:0]              ioctl_ext_i;
	logic                     model_i;
	logic                     boot_wr_o;
	logic [`BOOT_ADDR_W-1:0]  boot_addr_o;
	logic [`BANK_W-1:0]       boot_bank_o;
	logic [7:0]               boot_data_o;
	logic [`MAP_W-1:0]        rom_map_o;
	logic                     hold_reset_o;

	dl_entry_t          dl_tab [N_DL];
	logic [`MAP_W-1:0]  exp_map;
	int                 limit = 1000;
	int                 run_cyc = 0;
	int unsigned        seed_val;

	always #4 clk_sys = ~clk_sys;  // 8 ns

	boot_loader u_dut (.*);

	boot_checker u_chk (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.boot_wr_i   (boot_wr_o),
		.boot_addr_i (boot_addr_o),
		.boot_bank_i (boot_bank_o),
		.boot_data_i (boot_data_o)
	);

	bind boot_loader boot_loader_sva u_sva (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.ioctl_wr_i (ioctl_wr_i),
		.boot_wr_o  (boot_wr_o),
		.rom_map_o  (rom_map_o)
	);

	////////////////////////////////////////
	// Download table
	task automatic fill_table();
		// ROM set, blocks 0 to 8, block 8 dropped
		dl_tab[0] = '{8'd0, "  ", 1'b0, 25'h0000005, 25'h0004000, 9, 9'h000};
		dl_tab[1] = '{8'd0, "  ", 1'b1, 25'h0013FFF, 25'h0000001, 3, 9'h000};
		dl_tab[2] = '{8'd3, "07", 1'b0, 25'h0000000, 25'h0001001, 4, 9'h007};
		dl_tab[3] = '{8'd3, "C3", 1'b1, 25'h0003FFE, 25'h0000001, 4, 9'h0C3};
		dl_tab[4] = '{8'd3, "07", 1'b1, 25'h0000010, 25'h0000001, 2, 9'h007};
		dl_tab[5] = '{8'd3, "C3", 1'b0, 25'h0000020, 25'h0000001, 2, 9'h0C3};
		dl_tab[6] = '{8'd3, "Q1", 1'b0, 25'h0000100, 25'h0000001, 3, 9'h1EE};
		dl_tab[7] = '{8'd3, "ZZ", 1'b1, 25'h0000200, 25'h0000001, 2, 9'h000};
		// Combined images cross the end of block 0
		dl_tab[8] = '{8'd3, "Z0", 1'b0, 25'h0003FFD, 25'h0000001, 6, 9'h000};
		dl_tab[9] = '{8'd3, "Z0", 1'b1, 25'h0003FFF, 25'h0004000, 4, 9'h000};
	endtask

	task automatic run_download(input dl_entry_t e);
		logic [`IOCTL_ADDR_W-1:0] a;
		logic [`PAGE_W-1:0]       page;
		logic [`BOOT_ADDR_W-1:0]  ea;
		logic [`BANK_W-1:0]       eb;
		logic [10:0]              blk;
		logic [7:0]               d;
		logic                     combo;
		logic                     keep;
		int                       gap;
		page  = e.page;
		combo = (e.ext == "Z0");
		@(negedge clk_sys);
		ioctl_index_i    = e.idx;
		ioctl_ext_i      = e.ext;
		model_i          = e.model;
		ioctl_download_i = 1'b1;
		for (int i = 0; i < e.count; i++) begin
			gap = $urandom % (MAX_GAP + 1);
			repeat (gap) @(negedge clk_sys);
			a    = e.start + i * e.stride;
			d    = $urandom;
			keep = 1'b1;
			ioctl_wr_i   = 1'b1;
			ioctl_addr_i = a;
			ioctl_dout_i = d;
			if (e.idx == `DL_IDX_EXT) begin
				ea = {page[8], page[7:0] + a[21:14], a[13:0]};
				eb = {1'b0, e.model};
				if (combo && (&a[13:0])) begin
					page  = `PAGE_COMBO;  // Following blocks shift into the upper half
					combo = 1'b0;
				end
			end else begin
				blk = a[24:14];
				eb  = {1'b0, blk[2]};
				keep = (blk <= 11'd7);
				case (blk[1:0])
					2'd0: ea = {`PAGE_OS, a[13:0]};
					2'd1: ea = {`PAGE_BASIC, a[13:0]};
					2'd2: ea = {`PAGE_AMSDOS, a[13:0]};
					default: ea = {`PAGE_CART, a[13:0]};
				endcase
			end
			if (keep) begin
				u_chk.push_write(ea, eb, d);
				if (ea[22])
					exp_map[ea[21:14]] = 1'b1;
			end
			@(negedge clk_sys);
			ioctl_wr_i = 1'b0;
			if (i == 0) begin
				u_chk.check_value("hold_reset_o", hold_reset_o, 1);
				// Model and page stay as latched at the download start
				model_i     = ~e.model;
				ioctl_ext_i = 16'h0000;
			end
		end
		ioctl_download_i = 1'b0;
		while (u_chk.pending() != 0)
			@(negedge clk_sys);
		repeat (2) @(negedge clk_sys);
		u_chk.check_value("hold_reset_o", hold_reset_o, 0);
	endtask

	// Run limit from the table length
	always @(posedge clk_sys) begin
		run_cyc <= run_cyc + 1;
		if (run_cyc >= limit) begin
			$display("Run stopped by timeout after %0d cycles", run_cyc);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin : main_blk
		int total;
		seed_val         = $urandom(1);
		reset            = 1'b1;
		ioctl_download_i = 1'b0;
		ioctl_index_i    = 8'd0;
		ioctl_wr_i       = 1'b0;
		ioctl_addr_i     = '0;
		ioctl_dout_i     = 8'd0;
		ioctl_ext_i      = 16'd0;
		model_i          = 1'b0;
		exp_map          = '0;
		fill_table();
		total = 0;
		for (int k = 0; k < N_DL; k++)
			total += dl_tab[k].count;
		limit = 2 * total * MAX_GAP + 100;
		repeat (10) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		for (int k = 0; k < N_DL; k++)
			run_download(dl_tab[k]);
		u_chk.check_value("rom_map_o", rom_map_o, exp_map);
		u_chk.final_check();
		$display("Writes checked %0d, errors %0d", u_chk.wr_cnt, u_chk.err_cnt);
		if (u_chk.err_cnt == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule
